//--- logic/fetchPkg.sv
/*
  Shared definitions for the first fetch stage.
  Address width, bundle and slot geometry, and the control-instruction
  type encoding used by the BTB, the sequencer and the update path.
*/

package fetchPkg;

  // ------------------------------------------------------------------------
  // Address and bundle geometry
  // ------------------------------------------------------------------------
  localparam int PC_WIDTH     = 32;  // Every address in the front end
  localparam int FETCH_WIDTH  = 4;   // Slots per fetch bundle
  localparam int INST_BYTES   = 8;   // Bytes per slot
  localparam int BUNDLE_BYTES = 32;  // Sequential PC increment
  localparam int SLOT_BITS    = 2;   // Slot index sits in PC[4:3]

  // ------------------------------------------------------------------------
  // Control-instruction type, as stored in the BTB and sent with updates
  // ------------------------------------------------------------------------
  typedef enum logic [1:0] {
    RETURN = 2'd0,  // Target comes from the RAS
    CALL   = 2'd1,  // Pushes the return address
    JUMP   = 2'd2,  // Unconditional, direct or indirect
    COND   = 2'd3   // Direction from the bimodal counter
  } brType_t;

endpackage

//--- logic/updateDecoder.sv
/*
  Steers one program-order branch update to the slot bank that owns it.
  The slot comes from PC[4:3]; counters train on COND only, and a
  not-taken COND leaves the BTB alone. Purely combinational.
*/

`timescale 1ns/1ps

module updateDecoder #(
  parameter int BTB_ENTRIES = 16
) (
  input  logic                              updateEn_i,
  input  logic [fetchPkg::PC_WIDTH-1:0]     updatePC_i,
  input  fetchPkg::brType_t                 updateType_i,
  input  logic                              updateDir_i,
  output logic [fetchPkg::FETCH_WIDTH-1:0]  btbWrEn_o,
  output logic [fetchPkg::FETCH_WIDTH-1:0]  ctrWrEn_o,
  output logic [$clog2(BTB_ENTRIES)-1:0]    wrIndex_o
);

  import fetchPkg::*;

  localparam int SLOT_LSB = $clog2(INST_BYTES);    // Lowest slot-index bit
  localparam int IDX_LSB  = $clog2(BUNDLE_BYTES);  // Bundle address starts here
  localparam int IDX_BITS = $clog2(BTB_ENTRIES);

  logic [SLOT_BITS-1:0] updSlot;   // Slot position of the updated branch
  logic                 isCond;
  logic                 btbWrite;  // Any bank gets a BTB write
  logic                 ctrWrite;  // Any bank gets a counter step

  assign updSlot  = updatePC_i[SLOT_LSB +: SLOT_BITS];
  assign isCond   = (updateType_i == COND);
  assign btbWrite = updateEn_i & (~isCond | updateDir_i);  // Skip not-taken COND
  assign ctrWrite = updateEn_i & isCond;                   // Only COND has a counter

  // One-hot decode of the owning slot
  always_comb begin
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      btbWrEn_o[s] = btbWrite & (updSlot == SLOT_BITS'(s));
      ctrWrEn_o[s] = ctrWrite & (updSlot == SLOT_BITS'(s));
    end
  end

  assign wrIndex_o = updatePC_i[IDX_LSB +: IDX_BITS];  // Bundle-address index

endmodule

//--- logic/slotPredictor.sv
/*
  BTB bank and bimodal direction counters for one slot position.
  Lookup is combinational on the fetch PC's bundle address; updates
  write the entry or step the 2-bit counter at the clock edge.
*/

`timescale 1ns/1ps

module slotPredictor #(
  parameter int BTB_ENTRIES = 16
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [fetchPkg::PC_WIDTH-1:0]   pc_i,
  input  logic                            btbWrEn_i,
  input  logic                            ctrWrEn_i,
  input  logic [$clog2(BTB_ENTRIES)-1:0]  wrIndex_i,
  input  logic [fetchPkg::PC_WIDTH-1:0]   updatePC_i,
  input  logic [fetchPkg::PC_WIDTH-1:0]   updateTarget_i,
  input  fetchPkg::brType_t               updateType_i,
  input  logic                            updateDir_i,
  output logic                            hit_o,
  output fetchPkg::brType_t               ctrlType_o,
  output logic [fetchPkg::PC_WIDTH-1:0]   target_o,
  output logic                            predTaken_o
);

  import fetchPkg::*;

  localparam int IDX_LSB  = $clog2(BUNDLE_BYTES);
  localparam int IDX_BITS = $clog2(BTB_ENTRIES);
  localparam int TAG_BITS = PC_WIDTH - IDX_LSB - IDX_BITS;  // Rest of bundle address

  // ------------------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------------------
  logic                btbValid  [BTB_ENTRIES];
  logic [TAG_BITS-1:0] btbTag    [BTB_ENTRIES];
  brType_t             btbType   [BTB_ENTRIES];
  logic [PC_WIDTH-1:0] btbTarget [BTB_ENTRIES];
  logic [1:0]          dirCtr    [BTB_ENTRIES];  // 2-bit saturating, MSB = taken

  logic [IDX_BITS-1:0] rdIndex;
  logic [TAG_BITS-1:0] rdTag;
  logic [TAG_BITS-1:0] wrTag;

  assign rdIndex = pc_i[IDX_LSB +: IDX_BITS];
  assign rdTag   = pc_i[PC_WIDTH-1 -: TAG_BITS];
  assign wrTag   = updatePC_i[PC_WIDTH-1 -: TAG_BITS];

  // ------------------------------------------------------------------------
  // Lookup
  // ------------------------------------------------------------------------
  assign hit_o       = btbValid[rdIndex] & (btbTag[rdIndex] == rdTag);
  assign ctrlType_o  = btbType[rdIndex];
  assign target_o    = btbTarget[rdIndex];
  assign predTaken_o = dirCtr[rdIndex][1];

  // ------------------------------------------------------------------------
  // Training
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < BTB_ENTRIES; i++) begin
        btbValid[i] <= 1'b0;   // Empty BTB
        dirCtr[i]   <= 2'b01;  // Weakly not taken
      end
    end else begin
      if (btbWrEn_i) begin
        btbValid[wrIndex_i] <= 1'b1;
        btbTag[wrIndex_i]   <= wrTag;
        btbType[wrIndex_i]  <= updateType_i;
      end
      if (ctrWrEn_i) begin
        if (updateDir_i && dirCtr[wrIndex_i] != 2'b11) begin
          dirCtr[wrIndex_i] <= dirCtr[wrIndex_i] + 2'b01;  // Toward taken
        end else if (!updateDir_i && dirCtr[wrIndex_i] != 2'b00) begin
          dirCtr[wrIndex_i] <= dirCtr[wrIndex_i] - 2'b01;  // Toward not taken
        end
      end
    end
  end

  // Target is payload only
  always_ff @(posedge clk) begin
    if (btbWrEn_i) btbTarget[wrIndex_i] <= updateTarget_i;
  end

endmodule

//--- logic/returnStack.sv
/*
  Circular return address stack. Push advances the top pointer and
  overwrites the oldest entry once full; pop only moves the pointer.
  A decode-time repair push beats a speculative push or pop.
*/

`timescale 1ns/1ps

module returnStack #(
  parameter int RAS_DEPTH = 8
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           push_i,
  input  logic                           pop_i,
  input  logic [fetchPkg::PC_WIDTH-1:0]  pushAddr_i,
  input  logic                           repairPush_i,
  input  logic [fetchPkg::PC_WIDTH-1:0]  repairAddr_i,
  output logic [fetchPkg::PC_WIDTH-1:0]  top_o
);

  import fetchPkg::*;

  localparam int PTR_BITS = $clog2(RAS_DEPTH);

  logic [PC_WIDTH-1:0] stackMem [RAS_DEPTH];
  logic [PTR_BITS-1:0] topPtr;     // Points at the current top entry
  logic [PTR_BITS-1:0] topPtrInc;  // Wraps at RAS_DEPTH
  logic [PTR_BITS-1:0] topPtrDec;
  logic                doPush;
  logic [PC_WIDTH-1:0] pushData;

  assign topPtrInc = topPtr + 1'b1;
  assign topPtrDec = topPtr - 1'b1;
  assign doPush    = repairPush_i | push_i;
  assign pushData  = repairPush_i ? repairAddr_i : pushAddr_i;  // Repair wins

  always_ff @(posedge clk) begin
    if (reset) begin
      topPtr <= '0;
      for (int i = 0; i < RAS_DEPTH; i++) begin
        stackMem[i] <= '0;  // Empty stack reads a top of 0
      end
    end else if (doPush) begin
      topPtr             <= topPtrInc;
      stackMem[topPtrInc] <= pushData;  // Oldest entry lost when full
    end else if (pop_i) begin
      topPtr <= topPtrDec;  // Underflow wraps, data stays stale
    end
  end

  assign top_o = stackMem[topPtr];

endmodule

//--- logic/pcSequencer.sv
/*
  Fetch PC register and next-PC selection. Qualifies per-slot BTB hits
  with the direction counters, picks the lowest taken slot, and applies
  the fixed recovery priority. Also generates the RAS push and pop.
*/

`timescale 1ns/1ps

module pcSequencer (
  input  logic                                                  clk,
  input  logic                                                  reset,
  input  logic                                                  stall_i,
  input  logic                                                  recoverFlag_i,
  input  logic [fetchPkg::PC_WIDTH-1:0]                         recoverPC_i,
  input  logic                                                  exceptionFlag_i,
  input  logic [fetchPkg::PC_WIDTH-1:0]                         exceptionPC_i,
  input  logic                                                  flagRecoverEX_i,
  input  logic [fetchPkg::PC_WIDTH-1:0]                         targetEX_i,
  input  logic                                                  flagRecoverID_i,
  input  logic                                                  flagRtrID_i,
  input  logic [fetchPkg::PC_WIDTH-1:0]                         targetID_i,
  input  logic [fetchPkg::FETCH_WIDTH-1:0]                      hit_i,
  input  fetchPkg::brType_t [fetchPkg::FETCH_WIDTH-1:0]         ctrlType_i,
  input  logic [fetchPkg::FETCH_WIDTH-1:0][fetchPkg::PC_WIDTH-1:0] target_i,
  input  logic [fetchPkg::FETCH_WIDTH-1:0]                      predTaken_i,
  input  logic [fetchPkg::PC_WIDTH-1:0]                         rasTop_i,
  output logic                                                  push_o,
  output logic                                                  pop_o,
  output logic [fetchPkg::PC_WIDTH-1:0]                         pushAddr_o,
  output logic [fetchPkg::PC_WIDTH-1:0]                         pc_o
);

  import fetchPkg::*;

  logic [PC_WIDTH-1:0]    pcReg;
  logic [PC_WIDTH-1:0]    nextPC;
  logic [FETCH_WIDTH-1:0] slotTaken;    // Hit and predicted to redirect
  logic                   takenFound;
  brType_t                takenType;    // Type of the lowest taken slot
  logic [PC_WIDTH-1:0]    takenTarget;  // BTB target, or RAS top for a return
  logic [PC_WIDTH-1:0]    takenCallAddr;
  logic                   earlyRedirect;
  logic                   rasOpOk;

  // ------------------------------------------------------------------------
  // Slot qualification and lowest-slot select
  // ------------------------------------------------------------------------
  always_comb begin
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      slotTaken[s] = hit_i[s] & ((ctrlType_i[s] != COND) | predTaken_i[s]);
    end
  end

  // Walk from the top slot down so the lowest taken slot wins
  always_comb begin
    takenFound    = 1'b0;
    takenType     = JUMP;
    takenTarget   = '0;
    takenCallAddr = '0;
    for (int s = FETCH_WIDTH - 1; s >= 0; s--) begin
      if (slotTaken[s]) begin
        takenFound    = 1'b1;
        takenType     = ctrlType_i[s];
        takenTarget   = (ctrlType_i[s] == RETURN) ? rasTop_i : target_i[s];
        takenCallAddr = pcReg + PC_WIDTH'(INST_BYTES * (s + 1));  // Slot after the call
      end
    end
  end

  // ------------------------------------------------------------------------
  // Next-PC priority encoder
  // ------------------------------------------------------------------------
  always_comb begin
    if (flagRecoverEX_i) begin
      nextPC = targetEX_i;  // Indirect mispredict from execute
    end else if (flagRecoverID_i) begin
      nextPC = flagRtrID_i ? rasTop_i : targetID_i;  // Decode-time fix
    end else if (takenFound) begin
      nextPC = takenTarget;
    end else begin
      nextPC = pcReg + PC_WIDTH'(BUNDLE_BYTES);  // Sequential bundle
    end
  end

  // RAS ops follow the prediction only when it is actually used
  assign earlyRedirect = flagRecoverEX_i | flagRecoverID_i;
  assign rasOpOk       = ~stall_i & ~earlyRedirect;
  assign push_o        = rasOpOk & takenFound & (takenType == CALL);
  assign pop_o         = rasOpOk & takenFound & (takenType == RETURN);
  assign pushAddr_o    = takenCallAddr;

  // ------------------------------------------------------------------------
  // PC register
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      pcReg <= '0;
    end else if (recoverFlag_i) begin
      pcReg <= recoverPC_i;  // Full pipeline recovery
    end else if (exceptionFlag_i) begin
      pcReg <= exceptionPC_i;
    end else if (flagRecoverEX_i || !stall_i) begin
      pcReg <= nextPC;  // EX redirect gets through a stall
    end
  end

  assign pc_o = pcReg;

endmodule

//--- logic/fetchStage1.sv
/*
  First fetch stage top level. Connects the update decoder, one
  BTB/counter bank per slot, the return address stack and the PC
  sequencer. pc_o is the bundle address fetched this cycle.
*/

`timescale 1ns/1ps

module fetchStage1 #(
  parameter int BTB_ENTRIES = 16,
  parameter int RAS_DEPTH   = 8
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           stall_i,
  input  logic                           recoverFlag_i,
  input  logic [fetchPkg::PC_WIDTH-1:0]  recoverPC_i,
  input  logic                           exceptionFlag_i,
  input  logic [fetchPkg::PC_WIDTH-1:0]  exceptionPC_i,
  input  logic                           flagRecoverEX_i,
  input  logic [fetchPkg::PC_WIDTH-1:0]  targetEX_i,
  input  logic                           flagRecoverID_i,
  input  logic                           flagRtrID_i,
  input  logic [fetchPkg::PC_WIDTH-1:0]  targetID_i,
  input  logic                           flagCallID_i,
  input  logic [fetchPkg::PC_WIDTH-1:0]  callPCID_i,
  input  logic                           updateEn_i,
  input  logic [fetchPkg::PC_WIDTH-1:0]  updatePC_i,
  input  logic [fetchPkg::PC_WIDTH-1:0]  updateTarget_i,
  input  fetchPkg::brType_t              updateType_i,
  input  logic                           updateDir_i,
  output logic [fetchPkg::PC_WIDTH-1:0]  pc_o
);

  import fetchPkg::*;

  logic [FETCH_WIDTH-1:0]               btbWrEn;
  logic [FETCH_WIDTH-1:0]               ctrWrEn;
  logic [$clog2(BTB_ENTRIES)-1:0]       wrIndex;
  logic [FETCH_WIDTH-1:0]               slotHit;
  brType_t [FETCH_WIDTH-1:0]            slotType;
  logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0] slotTarget;
  logic [FETCH_WIDTH-1:0]               slotPredTaken;
  logic                                 rasPush;
  logic                                 rasPop;
  logic [PC_WIDTH-1:0]                  rasPushAddr;
  logic [PC_WIDTH-1:0]                  rasTop;
  logic                                 rasRepair;

  updateDecoder #(.BTB_ENTRIES(BTB_ENTRIES)) updDec (
    .updateEn_i(updateEn_i), .updatePC_i(updatePC_i), .updateType_i(updateType_i),
    .updateDir_i(updateDir_i), .btbWrEn_o(btbWrEn), .ctrWrEn_o(ctrWrEn),
    .wrIndex_o(wrIndex)
  );

  // One BTB and counter bank per slot position
  for (genvar s = 0; s < FETCH_WIDTH; s++) begin : gSlot
    slotPredictor #(.BTB_ENTRIES(BTB_ENTRIES)) slotPred (
      .clk(clk), .reset(reset), .pc_i(pc_o),
      .btbWrEn_i(btbWrEn[s]), .ctrWrEn_i(ctrWrEn[s]), .wrIndex_i(wrIndex),
      .updatePC_i(updatePC_i), .updateTarget_i(updateTarget_i),
      .updateType_i(updateType_i), .updateDir_i(updateDir_i),
      .hit_o(slotHit[s]), .ctrlType_o(slotType[s]),
      .target_o(slotTarget[s]), .predTaken_o(slotPredTaken[s])
    );
  end

  // Missed call seen at decode, held off while stalled
  assign rasRepair = flagRecoverID_i & flagCallID_i & ~stall_i;

  returnStack #(.RAS_DEPTH(RAS_DEPTH)) ras (
    .clk(clk), .reset(reset), .push_i(rasPush), .pop_i(rasPop),
    .pushAddr_i(rasPushAddr), .repairPush_i(rasRepair),
    .repairAddr_i(callPCID_i), .top_o(rasTop)
  );

  pcSequencer pcSeq (
    .clk(clk), .reset(reset), .stall_i(stall_i),
    .recoverFlag_i(recoverFlag_i), .recoverPC_i(recoverPC_i),
    .exceptionFlag_i(exceptionFlag_i), .exceptionPC_i(exceptionPC_i),
    .flagRecoverEX_i(flagRecoverEX_i), .targetEX_i(targetEX_i),
    .flagRecoverID_i(flagRecoverID_i), .flagRtrID_i(flagRtrID_i),
    .targetID_i(targetID_i), .hit_i(slotHit), .ctrlType_i(slotType),
    .target_i(slotTarget), .predTaken_i(slotPredTaken), .rasTop_i(rasTop),
    .push_o(rasPush), .pop_o(rasPop), .pushAddr_o(rasPushAddr), .pc_o(pc_o)
  );

endmodule

//--- tests/clockGen.sv
/*
  Clock and reset source for the fetch stage testbench.
  Free-running clock of PERIOD_NS, reset held high for RESET_CYCLES edges.
*/

`timescale 1ns/1ps

module clockGen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    reset_o <= 1'b0;  // Released on a rising edge
  end

endmodule

//--- tests/fetchStage1_sva.sv
/*
  Concurrent checks on the fetch PC, bound into every fetchStage1.
  Covers the reset value, the stall hold and the full recovery load.
  failCount is read by the testbench to end the run.
*/

`timescale 1ns/1ps

module fetchStage1_sva (
  input logic                           clk,
  input logic                           reset,
  input logic                           stall_i,
  input logic                           recoverFlag_i,
  input logic [fetchPkg::PC_WIDTH-1:0]  recoverPC_i,
  input logic                           exceptionFlag_i,
  input logic                           flagRecoverEX_i,
  input logic [fetchPkg::PC_WIDTH-1:0]  pc_i
);

  int   failCount = 0;  // Assertion failures so far
  logic forcedMove;     // Redirects that get through a stall

  assign forcedMove = recoverFlag_i | exceptionFlag_i | flagRecoverEX_i;

  resetToZero: assert property (@(posedge clk) reset |=> pc_i == '0)
    else begin
      failCount++;
      $error("pc_o is not zero in the cycle after reset");
    end

  stallHolds: assert property (@(posedge clk) disable iff (reset)
    (stall_i && !forcedMove) |=> $stable(pc_i))
    else begin
      failCount++;
      $error("pc_o moved while stalled without a redirect");
    end

  recoverLoads: assert property (@(posedge clk) disable iff (reset)
    recoverFlag_i |=> pc_i == $past(recoverPC_i))
    else begin
      failCount++;
      $error("pc_o did not load recoverPC_i after a recovery");
    end

endmodule

bind fetchStage1 fetchStage1_sva svaCheck (
  .clk(clk), .reset(reset), .stall_i(stall_i), .recoverFlag_i(recoverFlag_i),
  .recoverPC_i(recoverPC_i), .exceptionFlag_i(exceptionFlag_i),
  .flagRecoverEX_i(flagRecoverEX_i), .pc_i(pc_o)
);

//--- tests/fetchStage1Tb.sv
/*
  Testbench for the first fetch stage. Runs sequential fetch, BTB jump
  and counter training, call/return nesting and redirect priority, and
  compares pc_o every cycle with a reference model of the next-PC rules.
*/

`timescale 1ns/1ps

module fetchStage1Tb;

  import fetchPkg::*;

  localparam int BTB_ENTRIES    = 16;
  localparam int RAS_DEPTH      = 8;
  localparam int CLK_PERIOD     = 20;
  localparam int PLANNED_CYCLES = 90;  // Reset plus the five scenarios
  localparam int WATCHDOG_NS    = (PLANNED_CYCLES + 40) * CLK_PERIOD;

  logic                clk;
  logic                reset;
  logic                stall;
  logic                recoverFlag;
  logic [PC_WIDTH-1:0] recoverPC;
  logic                exceptionFlag;
  logic [PC_WIDTH-1:0] exceptionPC;
  logic                flagRecoverEX;
  logic [PC_WIDTH-1:0] targetEX;
  logic                flagRecoverID;
  logic                flagRtrID;
  logic [PC_WIDTH-1:0] targetID;
  logic                flagCallID;
  logic [PC_WIDTH-1:0] callPCID;
  logic                updateEn;
  logic [PC_WIDTH-1:0] updatePC;
  logic [PC_WIDTH-1:0] updateTarget;
  brType_t             updateType;
  logic                updateDir;
  logic [PC_WIDTH-1:0] pcOut;

  // Reference model state
  logic [PC_WIDTH-1:0]          expPC;
  logic                         modelLive = 1'b0;
  logic                         mValid  [FETCH_WIDTH][BTB_ENTRIES];
  logic [PC_WIDTH-1:0]          mBundle [FETCH_WIDTH][BTB_ENTRIES];  // Bundle number
  brType_t                      mType   [FETCH_WIDTH][BTB_ENTRIES];
  logic [PC_WIDTH-1:0]          mTarget [FETCH_WIDTH][BTB_ENTRIES];
  logic [1:0]                   mCtr    [FETCH_WIDTH][BTB_ENTRIES];
  logic [PC_WIDTH-1:0]          mRas    [RAS_DEPTH];
  logic [$clog2(RAS_DEPTH)-1:0] mPtr;

  string               testName = "reset";
  logic [31:0]         lcgState = 32'h289e_3fce;
  logic [PC_WIDTH-1:0] jAddr;
  logic [PC_WIDTH-1:0] jBundle;
  logic [PC_WIDTH-1:0] jTarget;
  logic [PC_WIDTH-1:0] cAddr;
  logic [PC_WIDTH-1:0] cTarget;

  clockGen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(5)) clkGen (.clk_o(clk), .reset_o(reset));

  fetchStage1 #(.BTB_ENTRIES(BTB_ENTRIES), .RAS_DEPTH(RAS_DEPTH)) DUT (
    .clk(clk), .reset(reset), .stall_i(stall),
    .recoverFlag_i(recoverFlag), .recoverPC_i(recoverPC),
    .exceptionFlag_i(exceptionFlag), .exceptionPC_i(exceptionPC),
    .flagRecoverEX_i(flagRecoverEX), .targetEX_i(targetEX),
    .flagRecoverID_i(flagRecoverID), .flagRtrID_i(flagRtrID), .targetID_i(targetID),
    .flagCallID_i(flagCallID), .callPCID_i(callPCID),
    .updateEn_i(updateEn), .updatePC_i(updatePC), .updateTarget_i(updateTarget),
    .updateType_i(updateType), .updateDir_i(updateDir), .pc_o(pcOut)
  );

  function automatic logic [31:0] lcgNext(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic reportFail();
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped on a failed check");
  endtask

  // --------------------------------------------------------------------------
  // Reference model of the next-PC, RAS and training rules
  // --------------------------------------------------------------------------
  task automatic resetModel();
    expPC = '0;
    mPtr  = '0;
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      for (int i = 0; i < BTB_ENTRIES; i++) begin
        mValid[s][i] = 1'b0;
        mCtr[s][i]   = 2'd1;  // Weakly not taken
      end
    end
    for (int i = 0; i < RAS_DEPTH; i++) mRas[i] = '0;
  endtask

  task automatic stepModel();
    int                  idx;
    int                  uIdx;
    int                  uSlot;
    int                  takenSlot;
    logic [PC_WIDTH-1:0] rasTop;
    logic [PC_WIDTH-1:0] nextPC;
    idx       = int'(expPC / BUNDLE_BYTES % BTB_ENTRIES);
    rasTop    = mRas[mPtr];
    takenSlot = -1;
    for (int s = FETCH_WIDTH - 1; s >= 0; s--) begin  // Lowest slot wins
      if (mValid[s][idx] && mBundle[s][idx] == expPC / BUNDLE_BYTES &&
          (mType[s][idx] != COND || mCtr[s][idx][1])) takenSlot = s;
    end
    if (flagRecoverEX) nextPC = targetEX;
    else if (flagRecoverID) nextPC = flagRtrID ? rasTop : targetID;
    else if (takenSlot >= 0) nextPC = (mType[takenSlot][idx] == RETURN) ? rasTop
                                                                       : mTarget[takenSlot][idx];
    else nextPC = expPC + BUNDLE_BYTES;
    if (flagRecoverID && flagCallID && !stall) begin  // Decode repair push
      mPtr       = mPtr + 1'b1;
      mRas[mPtr] = callPCID;
    end else if (!stall && !flagRecoverEX && !flagRecoverID && takenSlot >= 0) begin
      if (mType[takenSlot][idx] == CALL) begin
        mPtr       = mPtr + 1'b1;
        mRas[mPtr] = expPC + INST_BYTES * (takenSlot + 1);
      end else if (mType[takenSlot][idx] == RETURN) begin
        mPtr = mPtr - 1'b1;
      end
    end
    if (updateEn) begin
      uSlot = int'(updatePC / INST_BYTES % FETCH_WIDTH);
      uIdx  = int'(updatePC / BUNDLE_BYTES % BTB_ENTRIES);
      if (updateType != COND || updateDir) begin  // Not-taken COND skips the BTB
        mValid[uSlot][uIdx]  = 1'b1;
        mBundle[uSlot][uIdx] = updatePC / BUNDLE_BYTES;
        mType[uSlot][uIdx]   = updateType;
        mTarget[uSlot][uIdx] = updateTarget;
      end
      if (updateType == COND) begin
        if (updateDir && mCtr[uSlot][uIdx] != 2'd3) mCtr[uSlot][uIdx] += 2'd1;
        else if (!updateDir && mCtr[uSlot][uIdx] != 2'd0) mCtr[uSlot][uIdx] -= 2'd1;
      end
    end
    if (recoverFlag) expPC = recoverPC;
    else if (exceptionFlag) expPC = exceptionPC;
    else if (flagRecoverEX || !stall) expPC = nextPC;
  endtask

  always @(posedge clk) begin
    modelLive = 1'b1;
    if (reset) resetModel();
    else stepModel();
  end

  // Compare mid-cycle, away from the edge
  always @(negedge clk) begin
    if (modelLive && pcOut !== expPC) begin
      $display("ERROR test=%s expected=%h actual=%h", testName, expPC, pcOut);
      reportFail();
    end else if (DUT.svaCheck.failCount != 0) begin
      $display("A bound assertion on pc_o failed during test %s", testName);
      reportFail();
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    reportFail();
  end

  // --------------------------------------------------------------------------
  // Stimulus helpers, each starts on a rising edge
  // --------------------------------------------------------------------------
  task automatic train(input logic [PC_WIDTH-1:0] pc, input logic [PC_WIDTH-1:0] tgt,
                       input brType_t typ, input logic dir);
    @(posedge clk);
    updateEn     <= 1'b1;
    updatePC     <= pc;
    updateTarget <= tgt;
    updateType   <= typ;
    updateDir    <= dir;
    @(posedge clk);
    updateEn <= 1'b0;
  endtask

  task automatic recoverTo(input logic [PC_WIDTH-1:0] addr);
    @(posedge clk);
    recoverFlag <= 1'b1;
    recoverPC   <= addr;
    @(posedge clk);
    recoverFlag <= 1'b0;
  endtask

  task automatic holdStall(input int n);
    @(posedge clk);
    stall <= 1'b1;
    repeat (n) @(posedge clk);
    stall <= 1'b0;
  endtask

  initial begin
    stall         = 1'b0;
    recoverFlag   = 1'b0;
    recoverPC     = '0;
    exceptionFlag = 1'b0;
    exceptionPC   = '0;
    flagRecoverEX = 1'b0;
    targetEX      = '0;
    flagRecoverID = 1'b0;
    flagRtrID     = 1'b0;
    targetID      = '0;
    flagCallID    = 1'b0;
    callPCID      = '0;
    updateEn      = 1'b0;
    updatePC      = '0;
    updateTarget  = '0;
    updateType    = JUMP;
    updateDir     = 1'b0;
    while (reset !== 1'b0) @(posedge clk);

    testName = "sequential";
    repeat (6) @(posedge clk);
    holdStall(3);
    repeat (3) @(posedge clk);

    testName = "jump";
    lcgState = lcgNext(lcgState);
    jAddr    = 32'h0001_0000 | (lcgState & 32'h0000_0ff8);  // Random bundle and slot
    lcgState = lcgNext(lcgState);
    jTarget  = 32'h0002_0000 | (lcgState & 32'h0000_0fe0);
    jBundle  = jAddr & ~32'h1f;
    train(jAddr, jTarget, JUMP, 1'b1);
    recoverTo(jBundle - 32'd64);  // Walk into the bundle sequentially
    repeat (5) @(posedge clk);

    testName = "counter";
    lcgState = lcgNext(lcgState);
    cAddr    = 32'h0003_0000 | (lcgState & 32'h0000_0fe0) | 32'd16;  // Slot 2
    cTarget  = 32'h0004_0000 | (lcgState & 32'h0000_0fe0);
    for (int i = 0; i < 4; i++) begin  // Directions 0 1 1 0
      train(cAddr, cTarget, COND, i == 1 || i == 2);
      recoverTo(cAddr & ~32'h1f);
      repeat (3) @(posedge clk);
    end

    testName = "callReturn";
    train(32'h0005_0058, 32'h0006_0000, CALL, 1'b1);    // Slot 3 call
    train(32'h0006_0018, 32'h0007_0000, CALL, 1'b1);    // Nested call
    train(32'h0007_0000, 32'h0000_0000, RETURN, 1'b1);  // Inner return
    train(32'h0006_0028, 32'h0000_0000, RETURN, 1'b1);  // Outer return
    recoverTo(32'h0005_0040);
    repeat (8) @(posedge clk);

    testName = "priority";
    @(posedge clk);
    stall         <= 1'b1;
    recoverFlag   <= 1'b1;
    recoverPC     <= 32'h0009_0000;
    exceptionFlag <= 1'b1;
    exceptionPC   <= 32'h000a_0000;
    flagRecoverEX <= 1'b1;
    targetEX      <= 32'h000b_0000;
    flagRecoverID <= 1'b1;
    targetID      <= 32'h000c_0000;
    @(posedge clk);
    recoverFlag <= 1'b0;
    @(posedge clk);
    exceptionFlag <= 1'b0;
    @(posedge clk);
    flagRecoverEX <= 1'b0;  // ID alone cannot beat the stall
    @(posedge clk);
    stall         <= 1'b0;
    flagRecoverID <= 1'b0;
    recoverTo(jBundle);     // ID redirect while the BTB hits
    flagRecoverID <= 1'b1;
    targetID      <= 32'h000d_0000;
    flagCallID    <= 1'b1;
    callPCID      <= 32'h000e_0040;
    @(posedge clk);
    flagCallID <= 1'b0;
    flagRtrID  <= 1'b1;     // Back to the repaired RAS top
    @(posedge clk);
    flagRecoverID <= 1'b0;
    flagRtrID     <= 1'b0;
    repeat (3) @(posedge clk);

    testName = "end";
    @(negedge clk);
    if (DUT.svaCheck.failCount == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("Bound assertions reported a failure");
      reportFail();
    end
  end

endmodule

//--- src.f
logic/fetchPkg.sv
logic/updateDecoder.sv
logic/slotPredictor.sv
logic/returnStack.sv
logic/pcSequencer.sv
logic/fetchStage1.sv
tests/clockGen.sv
tests/fetchStage1_sva.sv
tests/fetchStage1Tb.sv

//--- run.sh
#!/bin/sh
# Build and run the fetch stage testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module fetchStage1Tb -f src.f -o simFetch
# Assertion errors are counted by the testbench, so the sim keeps running past them
./obj_dir/simFetch +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
if grep -q "Result: PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
